/* filelist.f */
+incdir+logic
logic/link_pkg.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/link_controller.sv
logic/bt_link_top.sv
verification/bt_link_tb.sv

/* Makefile */
TOP := bt_link_tb
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		--top-module $(TOP) -f filelist.f --Mdir $(BUILD) -o $(TOP)

run: compile
	./$(BUILD)/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* verification/bt_link_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth link testbench
// Loads commands, models the radio and reads replies
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "link_consts.svh"

module bt_link_tb
	import link_pkg::*;
();

	localparam int CLOCK_NS = 20;
	localparam int BIT_NS = CLOCK_NS * `LINK_CYCLES_PER_BIT;
	localparam int DEPTH = 1 << `LINK_FIFO_DEPTH_LOG2;
	localparam int RANDOM_TESTS = 6;
	// Twice the worst exchange of DEPTH + 1 frames each way plus gaps
	localparam int EXCHANGE_CYCLES =
		2 * (DEPTH + 1) * (20 * `LINK_CYCLES_PER_BIT + `LINK_GAP_CYCLES);
	localparam int WATCHDOG_NS = (RANDOM_TESTS + 2) * EXCHANGE_CYCLES * CLOCK_NS;

	typedef link_byte_t byte_queue_t[$];

	logic        clock = 1'b0;
	logic        reset;
	logic        fpga_rxd;
	link_byte_t  cmd_data;
	logic        user_data_loaded;
	logic        user_knows_stored;
	logic        user_data_done;
	logic        access_reply;
	logic        user_received_data;
	logic        finished_with_reply;
	logic        fpga_txd;
	logic        cmd_full;
	link_byte_t  reply_data;
	link_count_t reply_count;
	logic        data_stored_for_user;
	logic        data_ready_for_user;
	logic        link_busy;

	logic [15:0] lfsr = 16'd45574;
	// Bytes decoded from fpga_txd in arrival order
	link_byte_t  sent_bytes[$];

	bt_link_top i_bt_link_top (
		.clock                (clock),
		.reset                (reset),
		.fpga_rxd             (fpga_rxd),
		.cmd_data             (cmd_data),
		.user_data_loaded     (user_data_loaded),
		.user_knows_stored    (user_knows_stored),
		.user_data_done       (user_data_done),
		.access_reply         (access_reply),
		.user_received_data   (user_received_data),
		.finished_with_reply  (finished_with_reply),
		.fpga_txd             (fpga_txd),
		.cmd_full             (cmd_full),
		.reply_data           (reply_data),
		.reply_count          (reply_count),
		.data_stored_for_user (data_stored_for_user),
		.data_ready_for_user  (data_ready_for_user),
		.link_busy            (link_busy)
	);

	always #(CLOCK_NS / 2) clock = ~clock;

	task automatic fail_run(input string line);
		$display("%s", line);
		$display("Simulation FAILED");
		$fatal(1, "run stopped after an error");
	endtask

	task automatic check_byte(input link_byte_t actual, input link_byte_t expected,
		input string what);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0d ns: %s is 0x%02h, expected 0x%02h",
				$time, what, actual, expected));
	endtask

	task automatic check_count(input link_count_t actual, input link_count_t expected,
		input string what);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected)
			fail_run($sformatf("MISMATCH at %0d ns: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	// Taps 16, 14, 13, 11
	function automatic logic lfsr_step();
		logic feedback;
		feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], feedback};
		return feedback;
	endfunction

	function automatic int unsigned random_bits(input int count);
		int unsigned value;
		value = 0;
		for (int i = 0; i < count; i++)
			value = (value << 1) | lfsr_step();
		return value;
	endfunction

	function automatic link_byte_t command_byte();
		link_byte_t value;
		value = link_byte_t'(random_bits(8));
		// 0x2A would echo back as the line feed and cut the reply short
		if ((value ^ 8'h20) == `LINK_END_BYTE)
			value = value ^ 8'h01;
		return value;
	endfunction

	// Radio answers with every byte's case bit flipped and a closing line feed
	function automatic byte_queue_t expected_reply(input byte_queue_t command);
		byte_queue_t reply;
		foreach (command[i])
			reply.push_back(command[i] ^ 8'h20);
		reply.push_back(`LINK_END_BYTE);
		return reply;
	endfunction

	// Returns just after a rising edge where outputs are settled
	task tick();
		@(posedge clock);
		#1;
	endtask

	task automatic load_command_byte(input link_byte_t value, input logic last,
		input logic full_after);
		int delay;
		cmd_data = value;
		user_data_loaded = 1'b1;
		while (!data_stored_for_user)
			tick();
		user_data_loaded = 1'b0;
		check_count(reply_count, '0, "reply_count while loading");
		check_bit(cmd_full, full_after, "cmd_full after a load");
		delay = random_bits(2);
		repeat (delay)
		begin
			tick();
			check_bit(data_stored_for_user, 1'b1, "data_stored_for_user before ack");
		end
		user_knows_stored = 1'b1;
		user_data_done = last;
		while (data_stored_for_user)
			tick();
		user_knows_stored = 1'b0;
		user_data_done = 1'b0;
	endtask

	task automatic read_reply_byte(input link_byte_t expected, input logic last,
		input link_count_t count_before);
		int delay;
		check_count(reply_count, count_before, "reply_count before a read");
		// Head of the reply queue is the byte about to be taken
		check_byte(reply_data, expected, "reply_data");
		access_reply = 1'b1;
		while (!data_ready_for_user)
			tick();
		access_reply = 1'b0;
		check_count(reply_count, link_count_t'(count_before - 1), "reply_count after a read");
		check_bit(link_busy, 1'b1, "link_busy during readout");
		delay = random_bits(2);
		repeat (delay)
		begin
			tick();
			check_bit(data_ready_for_user, 1'b1, "data_ready_for_user before ack");
		end
		user_received_data = 1'b1;
		finished_with_reply = last;
		while (data_ready_for_user)
			tick();
		user_received_data = 1'b0;
		finished_with_reply = 1'b0;
	endtask

	// Radio side 8N1 frame sent LSB first
	task automatic send_rx_frame(input link_byte_t value);
		logic [9:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			fpga_rxd = frame[i];
			repeat (`LINK_CYCLES_PER_BIT)
				tick();
		end
	endtask

	task automatic run_exchange(input int load_len);
		byte_queue_t command;
		byte_queue_t sent;
		byte_queue_t reply;
		int sent_len;
		int read_len;
		link_byte_t value;
		sent_len = (load_len > DEPTH) ? DEPTH : load_len;
		for (int i = 0; i < load_len; i++)
			command.push_back(command_byte());
		for (int i = 0; i < load_len; i++)
			load_command_byte(command[i], i == load_len - 1, (i + 1) >= DEPTH);
		while (sent_bytes.size() < sent_len)
			tick();
		for (int i = 0; i < sent_len; i++)
		begin
			value = sent_bytes.pop_front();
			check_byte(value, command[i], $sformatf("fpga_txd byte %0d", i));
			sent.push_back(value);
		end
		// Last stop bit and rest gap pass before the controller listens
		repeat (`LINK_GAP_CYCLES + `LINK_CYCLES_PER_BIT)
			tick();
		reply = expected_reply(sent);
		foreach (reply[i])
			send_rx_frame(reply[i]);
		repeat (`LINK_CYCLES_PER_BIT)
			tick();
		// Bytes past the queue depth are lost
		read_len = (reply.size() > DEPTH) ? DEPTH : reply.size();
		check_count(reply_count, link_count_t'(read_len), "reply_count after the reply");
		for (int k = 0; k < read_len; k++)
			read_reply_byte(reply[k], k == read_len - 1, link_count_t'(read_len - k));
		tick();
		check_bit(link_busy, 1'b0, "link_busy after finished_with_reply");
		if (sent_bytes.size() != 0)
			fail_run("More bytes left on fpga_txd than the command queue can hold");
	endtask

	// Serial monitor on the transmit line
	initial
	begin : txd_monitor
		link_byte_t value;
		forever
		begin
			@(negedge fpga_txd);
			#(BIT_NS / 2);
			if (fpga_txd !== 1'b0)
				fail_run("Start bit on fpga_txd did not stay low to mid-bit");
			for (int i = 0; i < 8; i++)
			begin
				#(BIT_NS);
				value[i] = fpga_txd;
			end
			#(BIT_NS);
			if (fpga_txd !== 1'b1)
				fail_run("Stop bit on fpga_txd was not high");
			sent_bytes.push_back(value);
		end
	end

	initial
	begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: the exchanges did not complete in the expected time");
		$display("Simulation FAILED");
		$fatal(1, "watchdog expired");
	end

	initial
	begin : stimulus
		int length;
		reset = 1'b1;
		fpga_rxd = 1'b1;
		cmd_data = '0;
		user_data_loaded = 1'b0;
		user_knows_stored = 1'b0;
		user_data_done = 1'b0;
		access_reply = 1'b0;
		user_received_data = 1'b0;
		finished_with_reply = 1'b0;
		repeat (2)
			@(posedge clock);
		#1;
		reset = 1'b0;
		tick();
		check_bit(fpga_txd, 1'b1, "fpga_txd after reset");
		check_bit(link_busy, 1'b0, "link_busy after reset");
		check_bit(data_stored_for_user, 1'b0, "data_stored_for_user after reset");
		check_bit(data_ready_for_user, 1'b0, "data_ready_for_user after reset");
		for (int t = 0; t < RANDOM_TESTS; t++)
		begin
			length = 1 + random_bits(4);
			run_exchange(length);
			repeat (random_bits(2))
				tick();
		end
		// One byte more than the command queue holds
		run_exchange(DEPTH + 1);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* logic/bt_link_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth link top level
// Command and reply queues around the UART pair
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bt_link_top
	import link_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        fpga_rxd,
	input  link_byte_t  cmd_data,
	input  logic        user_data_loaded,
	input  logic        user_knows_stored,
	input  logic        user_data_done,
	input  logic        access_reply,
	input  logic        user_received_data,
	input  logic        finished_with_reply,
	output logic        fpga_txd,
	output logic        cmd_full,
	output link_byte_t  reply_data,
	output link_count_t reply_count,
	output logic        data_stored_for_user,
	output logic        data_ready_for_user,
	output logic        link_busy
);

	logic       cmd_write;
	logic       cmd_read;
	logic       cmd_empty;
	link_byte_t cmd_head;
	logic       tx_start;
	logic       tx_done;
	link_byte_t rx_byte;
	logic       rx_valid;
	logic       reply_write;
	logic       reply_read;
	logic       reply_empty;

	// Transmit path
	byte_fifo cmd_queue (
		.clock      (clock),
		.reset      (reset),
		.write      (cmd_write),
		.read       (cmd_read),
		.write_data (cmd_data),
		.head       (cmd_head),
		.full       (cmd_full),
		.empty      (cmd_empty),
		.count      ()
	);

	uart_tx i_uart_tx (
		.clock (clock),
		.reset (reset),
		.start (tx_start),
		.data  (cmd_head),
		.txd   (fpga_txd),
		.done  (tx_done)
	);

	// Receive path
	uart_rx i_uart_rx (
		.clock    (clock),
		.reset    (reset),
		.rxd      (fpga_rxd),
		.byte_out (rx_byte),
		.valid    (rx_valid)
	);

	byte_fifo reply_queue (
		.clock      (clock),
		.reset      (reset),
		.write      (reply_write),
		.read       (reply_read),
		.write_data (rx_byte),
		.head       (reply_data),
		.full       (),
		.empty      (reply_empty),
		.count      (reply_count)
	);

	link_controller i_link_controller (
		.clock                (clock),
		.reset                (reset),
		.user_data_loaded     (user_data_loaded),
		.user_knows_stored    (user_knows_stored),
		.user_data_done       (user_data_done),
		.access_reply         (access_reply),
		.user_received_data   (user_received_data),
		.finished_with_reply  (finished_with_reply),
		.cmd_empty            (cmd_empty),
		.tx_done              (tx_done),
		.rx_valid             (rx_valid),
		.rx_byte              (rx_byte),
		.reply_empty          (reply_empty),
		.cmd_write            (cmd_write),
		.cmd_read             (cmd_read),
		.tx_start             (tx_start),
		.reply_write          (reply_write),
		.reply_read           (reply_read),
		.data_stored_for_user (data_stored_for_user),
		.data_ready_for_user  (data_ready_for_user),
		.link_busy            (link_busy)
	);

endmodule

/* logic/link_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Link controller
// Sequences command load, transmit, reply capture and readout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "link_consts.svh"

module link_controller
	import link_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       user_data_loaded,
	input  logic       user_knows_stored,
	input  logic       user_data_done,
	input  logic       access_reply,
	input  logic       user_received_data,
	input  logic       finished_with_reply,
	input  logic       cmd_empty,
	input  logic       tx_done,
	input  logic       rx_valid,
	input  link_byte_t rx_byte,
	input  logic       reply_empty,
	output logic       cmd_write,
	output logic       cmd_read,
	output logic       tx_start,
	output logic       reply_write,
	output logic       reply_read,
	output logic       data_stored_for_user,
	output logic       data_ready_for_user,
	output logic       link_busy
);

	localparam int GAP_W = $clog2(`LINK_GAP_CYCLES);
	localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`LINK_GAP_CYCLES - 1);

	link_state_t      state;
	link_state_t      next;
	logic [GAP_W-1:0] gap_cnt;
	logic             gap_done;
	logic             end_seen;

	assign gap_done = (gap_cnt == GAP_LAST);
	assign end_seen = rx_valid && (rx_byte == `LINK_END_BYTE);

	always_comb
	begin
		next = state;
		case (state)
			idle:
			begin
				if (user_data_loaded)
					next = load_cmd;
			end
			load_cmd:
				next = rest_cmd;
			// Hold until the user has seen the byte go in
			rest_cmd:
			begin
				if (user_knows_stored)
				begin
					if (user_data_done)
						next = load_byte;
					else
						next = idle;
				end
			end
			load_byte:
			begin
				if (cmd_empty)
					next = idle;
				else
					next = send_byte;
			end
			send_byte:
			begin
				if (tx_done)
					next = rest_gap;
			end
			rest_gap:
			begin
				if (gap_done)
				begin
					if (cmd_empty)
						next = await_reply;
					else
						next = load_byte;
				end
			end
			await_reply:
			begin
				if (end_seen)
					next = await_request;
			end
			// Nothing to hand out yet
			await_request:
			begin
				if (access_reply && !reply_empty)
					next = read_reply;
			end
			read_reply:
				next = rest_reply;
			rest_reply:
			begin
				if (user_received_data)
				begin
					if (finished_with_reply)
						next = idle;
					else
						next = await_request;
				end
			end
			default:
				next = idle;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			gap_cnt <= '0;
			tx_start <= 1'b0;
		end
		else
		begin
			state <= next;
			// Gap timer only runs while resting after a byte
			if (state == rest_gap)
				gap_cnt <= gap_cnt + 1'b1;
			else
				gap_cnt <= '0;
			// One pulse as send_byte is entered
			tx_start <= (state == load_byte) && !cmd_empty;
		end
	end

	assign cmd_write = (state == load_cmd);
	// Sent byte leaves the queue when its frame completes
	assign cmd_read = (state == send_byte) && tx_done;
	assign reply_write = (state == await_reply) && rx_valid;
	assign reply_read = (state == read_reply);

	assign data_stored_for_user = (state == rest_cmd);
	assign data_ready_for_user = (state == rest_reply);
	assign link_busy = (state != idle);

	// The byte at the queue head is what the transmitter latches
	a_start_has_byte: assert property (@(posedge clock) disable iff (reset)
		tx_start |-> !cmd_empty);

	a_user_levels_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(data_stored_for_user && data_ready_for_user));

endmodule

/* logic/uart_rx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART receiver
// Mid-bit sampling of 8N1 frames with stop check
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "link_consts.svh"

module uart_rx
	import link_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       rxd,
	output link_byte_t byte_out,
	output logic       valid
);

	localparam int CNT_W = $clog2(`LINK_CYCLES_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`LINK_CYCLES_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`LINK_CYCLES_PER_BIT / 2 - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;

	logic             rxd_meta;
	logic             rxd_sync;
	logic             rxd_prev;
	logic             busy;
	logic [CNT_W-1:0] cycle_cnt;
	logic [3:0]       bit_idx;
	link_byte_t       shift;
	logic             start_edge;
	logic             sample;

	assign start_edge = !busy && rxd_prev && !rxd_sync;
	assign sample = busy && (cycle_cnt == '0);
	assign byte_out = shift;

	// Two flops against metastability, one more for the edge
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cycle_cnt <= '0;
			bit_idx <= '0;
			valid <= 1'b0;
		end
		else
		begin
			valid <= 1'b0;
			if (start_edge)
			begin
				// First sample lands in the middle of the start bit
				busy <= 1'b1;
				cycle_cnt <= HALF_BIT;
				bit_idx <= '0;
			end
			else if (sample)
			begin
				cycle_cnt <= FULL_BIT;
				bit_idx <= bit_idx + 4'd1;
				if (bit_idx == '0 && rxd_sync)
					busy <= 1'b0;
				else if (bit_idx == STOP_BIT)
				begin
					busy <= 1'b0;
					// Bad stop bit drops the frame
					valid <= rxd_sync;
				end
			end
			else if (busy)
				cycle_cnt <= cycle_cnt - 1'b1;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (sample && bit_idx != '0 && bit_idx != STOP_BIT)
			shift <= {rxd_sync, shift[7:1]};
	end

endmodule

/* logic/uart_tx.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART transmitter
// Sends one 8N1 frame per start pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "link_consts.svh"

module uart_tx
	import link_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  logic       start,
	input  link_byte_t data,
	output logic       txd,
	output logic       done
);

	localparam int CNT_W = $clog2(`LINK_CYCLES_PER_BIT);
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`LINK_CYCLES_PER_BIT - 1);
	localparam logic [3:0] STOP_BIT = 4'd9;

	logic             busy;
	logic [CNT_W-1:0] cycle_cnt;
	logic [3:0]       bit_idx;
	logic [9:0]       frame;
	logic             bit_end;

	assign bit_end = busy && (cycle_cnt == LAST_CYCLE);

	// Line rests high between frames
	assign txd = busy ? frame[0] : 1'b1;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			cycle_cnt <= '0;
			bit_idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				cycle_cnt <= '0;
				bit_idx <= '0;
			end
			else if (bit_end)
			begin
				cycle_cnt <= '0;
				if (bit_idx == STOP_BIT)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
					bit_idx <= bit_idx + 4'd1;
			end
			else if (busy)
				cycle_cnt <= cycle_cnt + 1'b1;
		end
	end

	// Stop, data LSB first, start bit in position 0
	always_ff @(posedge clock)
	begin
		if (start)
			frame <= {1'b1, data, 1'b0};
		else if (bit_end)
			frame <= {1'b1, frame[9:1]};
	end

	// A new frame may only start once the last one is finished
	a_start_when_idle: assert property (@(posedge clock) disable iff (reset)
		start |-> !busy);

endmodule

/* logic/byte_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte queue
// First-word-fall-through circular buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "link_consts.svh"

module byte_fifo
	import link_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        write,
	input  logic        read,
	input  link_byte_t  write_data,
	output link_byte_t  head,
	output logic        full,
	output logic        empty,
	output link_count_t count
);

	localparam int DEPTH = 1 << `LINK_FIFO_DEPTH_LOG2;

	link_byte_t mem [DEPTH];
	logic [`LINK_FIFO_DEPTH_LOG2-1:0] wr_ptr;
	logic [`LINK_FIFO_DEPTH_LOG2-1:0] rd_ptr;
	logic do_write;
	logic do_read;

	// Writes into a full queue are lost
	assign do_write = write && !full;
	assign do_read = read && !empty;

	assign full = (count == link_count_t'(DEPTH));
	assign empty = (count == '0);

	// Oldest entry is always on the head
	assign head = mem[rd_ptr];

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_write && !do_read)
				count <= count + 1'b1;
			else if (do_read && !do_write)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (do_write)
			mem[wr_ptr] <= write_data;
	end

	// The reader must only pop what is there
	a_no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
		read |-> !empty);

endmodule

/* logic/link_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth link types
// Byte, queue count and controller state
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "link_consts.svh"

package link_pkg;

	// One serial data byte
	typedef logic [7:0] link_byte_t;

	// Fill level, one extra bit so a full queue can be told from empty
	typedef logic [`LINK_FIFO_DEPTH_LOG2:0] link_count_t;

	typedef enum logic [3:0]
	{
		idle,
		load_cmd,
		rest_cmd,
		load_byte,
		send_byte,
		rest_gap,
		await_reply,
		await_request,
		read_reply,
		rest_reply
	} link_state_t;

endpackage

/* logic/link_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bluetooth link constants
// Serial bit timing, rest gap, queue depth and reply terminator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// Clock cycles held for each serial bit
`define LINK_CYCLES_PER_BIT 16

// Quiet cycles after every transmitted byte
`define LINK_GAP_CYCLES 32

// Each queue holds 2**4 = 16 bytes
`define LINK_FIFO_DEPTH_LOG2 4

// Line feed closes a radio reply
`define LINK_END_BYTE 8'h0A

`endif
